// ==== src/common_pkg.sv ====
package common_pkg;

    localparam int CPU_ADDR_WIDTH  = 16;
    localparam int DATA_WIDTH      = 8;
    localparam int PHYS_ADDR_WIDTH = 17;

    typedef logic [CPU_ADDR_WIDTH-1:0]  cpu_addr_t;
    typedef logic [DATA_WIDTH-1:0]      data_t;
    typedef logic [PHYS_ADDR_WIDTH-1:0] phys_addr_t;
    typedef logic [DATA_WIDTH-1:0]      mem_ctl_t;

    // Bit positions in the 8096 memory control register
    localparam int MEM_CTL_ENABLE           = 7;
    localparam int MEM_CTL_IO_PEEK          = 6;
    localparam int MEM_CTL_SCREEN_PEEK      = 5;
    localparam int MEM_CTL_SELECT_HI        = 3;
    localparam int MEM_CTL_SELECT_LO        = 2;
    localparam int MEM_CTL_WRITE_PROTECT_HI = 1;
    localparam int MEM_CTL_WRITE_PROTECT_LO = 0;

    localparam cpu_addr_t MEM_CTL_ADDR = 16'hFFF0;

    localparam phys_addr_t VRAM_PHYS_BASE = 17'h08000;  // Screen memory in bank-less map

    // One CPU bus cycle
    typedef struct packed {
        cpu_addr_t addr;
        data_t     wdata;
        logic      write;
    } cpu_req_t;

    // One access to the shared array
    typedef struct packed {
        phys_addr_t addr;
        data_t      wdata;
        logic       write;
        logic       protect;    // Write is dropped by the array
    } mem_req_t;

    typedef struct packed {
        logic ram_en;
        logic is_vram;
        logic is_rom;
        logic sid_en;
        logic magic_en;
        logic pia1_en;
        logic pia2_en;
        logic via_en;
        logic crtc_en;
        logic io_en;
    } decode_t;

endpackage

// ==== src/memory_control.sv ====
`timescale 1ns/1ns

module memory_control import common_pkg::*; (
    input  logic      sys_clock_i,
    input  logic      reset_i,
    input  logic      wr_strobe_i,
    input  cpu_addr_t cpu_addr_i,
    input  data_t     cpu_data_i,

    output logic      bank_en_o,
    output logic      bank_a15_o,
    output logic      bank_ro_o
);
    mem_ctl_t mem_ctl;
    logic     in_lo_bank;
    logic     in_hi_bank;
    logic     screen_peek;
    logic     io_peek;

    always_ff @(posedge sys_clock_i) begin
        if (reset_i) begin
            mem_ctl <= '0;                          // Expansion off
        end else if (wr_strobe_i && cpu_addr_i == MEM_CTL_ADDR) begin
            mem_ctl <= cpu_data_i;
        end
    end

    always_comb begin
        in_lo_bank  = cpu_addr_i[15:14] == 2'b10;   // $8000-$BFFF
        in_hi_bank  = cpu_addr_i[15:14] == 2'b11;   // $C000-$FFFF

        // Peek-through windows stay on the base map
        screen_peek = mem_ctl[MEM_CTL_SCREEN_PEEK] && cpu_addr_i[15:12] == 4'h8;
        io_peek     = mem_ctl[MEM_CTL_IO_PEEK] && cpu_addr_i[15:11] == 5'b11101;

        bank_en_o   = mem_ctl[MEM_CTL_ENABLE]
                      && ((in_lo_bank && !screen_peek) || (in_hi_bank && !io_peek));

        bank_a15_o  = in_hi_bank ? mem_ctl[MEM_CTL_SELECT_HI]
                                 : mem_ctl[MEM_CTL_SELECT_LO];

        bank_ro_o   = bank_en_o && (in_hi_bank ? mem_ctl[MEM_CTL_WRITE_PROTECT_HI]
                                               : mem_ctl[MEM_CTL_WRITE_PROTECT_LO]);
    end

endmodule

// ==== src/address_decoding.sv ====
`timescale 1ns/1ns

module address_decoding import common_pkg::*; (
    input  logic     sys_clock_i,
    input  logic     reset_i,
    input  logic     cpu_be_i,
    input  logic     cpu_req_valid_i,
    input  cpu_req_t cpu_req_i,

    output decode_t  decode_o,
    output mem_req_t mem_req_o,
    output logic     mem_req_valid_o,
    output logic     mem_req_drop_o
);
    localparam decode_t DEC_NONE  = '0;
    localparam decode_t DEC_RAM   = '{ram_en: 1'b1, default: 1'b0};
    localparam decode_t DEC_VRAM  = '{ram_en: 1'b1, is_vram: 1'b1, default: 1'b0};
    localparam decode_t DEC_ROM   = '{ram_en: 1'b1, is_rom: 1'b1, default: 1'b0};
    localparam decode_t DEC_SID   = '{sid_en: 1'b1, default: 1'b0};
    localparam decode_t DEC_MAGIC = '{magic_en: 1'b1, default: 1'b0};
    localparam decode_t DEC_PIA1  = '{pia1_en: 1'b1, io_en: 1'b1, default: 1'b0};
    localparam decode_t DEC_PIA2  = '{pia2_en: 1'b1, io_en: 1'b1, default: 1'b0};
    localparam decode_t DEC_VIA   = '{via_en: 1'b1, io_en: 1'b1, default: 1'b0};
    localparam decode_t DEC_CRTC  = '{crtc_en: 1'b1, default: 1'b0};   // No io_en for CRTC

    logic      bank_en;
    logic      bank_a15;
    logic      bank_ro;
    cpu_addr_t addr;

    assign addr = cpu_req_i.addr;

    memory_control i_memory_control (
        .sys_clock_i (sys_clock_i),
        .reset_i     (reset_i),
        .wr_strobe_i (cpu_req_valid_i && cpu_be_i && cpu_req_i.write),
        .cpu_addr_i  (addr),
        .cpu_data_i  (cpu_req_i.wdata),
        .bank_en_o   (bank_en),
        .bank_a15_o  (bank_a15),
        .bank_ro_o   (bank_ro)
    );

    always_comb begin
        if (!cpu_be_i) begin
            decode_o = DEC_NONE;
        end else if (bank_en) begin
            decode_o = bank_ro ? DEC_ROM : DEC_RAM;             // Expansion bank hit
        end else begin
            priority casez (addr)
                16'b0???_????_????_????: decode_o = DEC_RAM;    // $0000-$7FFF
                16'b1000_1111_????_????: decode_o = DEC_SID;    // $8F00-$8FFF
                16'b1000_????_????_????: decode_o = DEC_VRAM;   // $8000-$8FFF
                16'b1110_1000_0000_????: decode_o = DEC_MAGIC;  // $E800-$E80F
                16'b1110_1000_0001_????: decode_o = DEC_PIA1;   // $E810-$E81F
                16'b1110_1000_001?_????: decode_o = DEC_PIA2;   // $E820-$E83F
                16'b1110_1000_01??_????: decode_o = DEC_VIA;    // $E840-$E87F
                16'b1110_1000_1???_????: decode_o = DEC_CRTC;   // $E880-$E8FF
                default:                 decode_o = DEC_ROM;
            endcase
        end
    end

    always_comb begin
        mem_req_o.addr    = {bank_en, bank_en ? bank_a15 : addr[15], addr[14:0]};
        mem_req_o.wdata   = cpu_req_i.wdata;
        mem_req_o.write   = cpu_req_i.write;
        mem_req_o.protect = decode_o.is_rom;    // ROM contents live in the array
    end

    assign mem_req_valid_o = cpu_req_valid_i && cpu_be_i;
    assign mem_req_drop_o  = cpu_req_valid_i && !cpu_be_i;   // Credit only, no access

endmodule

// ==== src/video_fetch.sv ====
`timescale 1ns/1ns

module video_fetch import common_pkg::*; #(
    parameter int CREDITS      = 2,
    parameter int SCREEN_CHARS = 1000
) (
    input  logic     sys_clock_i,
    input  logic     reset_i,
    input  logic     video_en_i,
    input  logic     credit_i,
    input  logic     rsp_valid_i,
    input  data_t    rsp_data_i,

    output mem_req_t req_o,
    output logic     req_valid_o,
    output logic     video_valid_o,
    output data_t    video_data_o
);
    localparam int IDX_W = (SCREEN_CHARS > 1) ? $clog2(SCREEN_CHARS) : 1;
    localparam int CNT_W = $clog2(CREDITS + 1);

    logic [CNT_W-1:0] credits_q;
    logic [IDX_W-1:0] index_q;

    assign req_valid_o = video_en_i && credits_q != '0;   // Stall without credit

    always_comb begin
        req_o      = '0;    // Read only
        req_o.addr = VRAM_PHYS_BASE + PHYS_ADDR_WIDTH'(index_q);
    end

    always_ff @(posedge sys_clock_i) begin
        if (reset_i) begin
            credits_q     <= CNT_W'(CREDITS);
            index_q       <= '0;
            video_valid_o <= 1'b0;
        end else begin
            credits_q     <= credits_q + CNT_W'(credit_i) - CNT_W'(req_valid_o);
            video_valid_o <= rsp_valid_i;
            if (req_valid_o) begin
                index_q <= (index_q == IDX_W'(SCREEN_CHARS - 1)) ? '0 : index_q + 1'b1;
            end
        end
    end

    always_ff @(posedge sys_clock_i) begin
        if (rsp_valid_i) video_data_o <= rsp_data_i;     // Arbiter keeps port order
    end

    assert property (@(posedge sys_clock_i) disable iff (reset_i)
        credits_q <= CNT_W'(CREDITS))
        else $error("video_fetch credit count above CREDITS");

endmodule

// ==== src/bus_arbiter.sv ====
`timescale 1ns/1ns

module bus_arbiter import common_pkg::*; #(
    parameter int CREDITS = 2
) (
    input  logic     sys_clock_i,
    input  logic     reset_i,

    input  mem_req_t cpu_req_i,
    input  logic     cpu_req_valid_i,
    input  logic     cpu_drop_i,
    output logic     cpu_credit_o,
    output logic     cpu_rsp_valid_o,
    output data_t    cpu_rsp_data_o,

    input  mem_req_t vid_req_i,
    input  logic     vid_req_valid_i,
    output logic     vid_credit_o,
    output logic     vid_rsp_valid_o,
    output data_t    vid_rsp_data_o,

    output mem_req_t mem_req_o,
    output logic     mem_en_o,
    input  data_t    mem_rdata_i
);
    localparam int PTR_W = (CREDITS > 1) ? $clog2(CREDITS) : 1;
    localparam int CNT_W = $clog2(CREDITS + 1);
    localparam int CPU   = 0;
    localparam int VID   = 1;

    typedef enum logic {LAST_CPU, LAST_VID} last_e;

    mem_req_t         queue    [2][CREDITS];
    mem_req_t         push_req [2];
    logic [PTR_W-1:0] wr_ptr   [2];
    logic [PTR_W-1:0] rd_ptr   [2];
    logic [CNT_W-1:0] count    [2];
    logic [1:0]       push;
    logic [1:0]       grant;
    logic [1:0]       not_empty;
    logic             cpu_ready;
    logic             drop_q;
    logic             cpu_rsp_q;
    logic             vid_rsp_q;
    last_e            last_q;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(CREDITS - 1)) return '0;
        return ptr + 1'b1;
    endfunction

    always_comb begin
        push            = {vid_req_valid_i, cpu_req_valid_i};
        push_req[CPU]   = cpu_req_i;
        push_req[VID]   = vid_req_i;
        not_empty[CPU]  = count[CPU] != '0;
        not_empty[VID]  = count[VID] != '0;
        cpu_ready       = not_empty[CPU] && !drop_q;   // Pending drop credit goes first

        grant = '0;
        if (cpu_ready && not_empty[VID]) begin
            grant = (last_q == LAST_CPU) ? 2'b10 : 2'b01;
        end else if (cpu_ready) begin
            grant = 2'b01;
        end else if (not_empty[VID]) begin
            grant = 2'b10;
        end
    end

    assign mem_req_o = grant[VID] ? queue[VID][rd_ptr[VID]] : queue[CPU][rd_ptr[CPU]];
    assign mem_en_o  = |grant;

    always_ff @(posedge sys_clock_i) begin
        for (int p = 0; p < 2; p++) begin
            if (push[p]) queue[p][wr_ptr[p]] <= push_req[p];
        end
    end

    always_ff @(posedge sys_clock_i) begin
        if (reset_i) begin
            for (int p = 0; p < 2; p++) begin
                wr_ptr[p] <= '0;
                rd_ptr[p] <= '0;
                count[p]  <= '0;
            end
            last_q    <= LAST_VID;
            drop_q    <= 1'b0;
            cpu_rsp_q <= 1'b0;
            vid_rsp_q <= 1'b0;
        end else begin
            for (int p = 0; p < 2; p++) begin
                if (push[p])  wr_ptr[p] <= next_ptr(wr_ptr[p]);
                if (grant[p]) rd_ptr[p] <= next_ptr(rd_ptr[p]);
                count[p] <= count[p] + CNT_W'(push[p]) - CNT_W'(grant[p]);
            end
            if (grant[CPU]) begin
                last_q <= LAST_CPU;
            end else if (grant[VID]) begin
                last_q <= LAST_VID;
            end
            drop_q    <= cpu_drop_i;
            cpu_rsp_q <= grant[CPU] && !mem_req_o.write;    // Writes get no response
            vid_rsp_q <= grant[VID];
        end
    end

    assign cpu_credit_o    = grant[CPU] || drop_q;
    assign vid_credit_o    = grant[VID];
    assign cpu_rsp_valid_o = cpu_rsp_q;
    assign cpu_rsp_data_o  = mem_rdata_i;
    assign vid_rsp_valid_o = vid_rsp_q;
    assign vid_rsp_data_o  = mem_rdata_i;

    // A requester that keeps to its credits never overruns its queue
    assert property (@(posedge sys_clock_i) disable iff (reset_i)
        !(push[CPU] && count[CPU] == CNT_W'(CREDITS))
        && !(push[VID] && count[VID] == CNT_W'(CREDITS)))
        else $error("push into full arbiter queue");

    // With both ports waiting the grant passes to the other port
    assert property (@(posedge sys_clock_i) disable iff (reset_i)
        grant[CPU] && not_empty[VID] |=> grant[VID])
        else $error("video port passed over after a CPU grant");

    assert property (@(posedge sys_clock_i) disable iff (reset_i)
        grant[VID] && not_empty[CPU] |=> grant[CPU] || drop_q)
        else $error("CPU port passed over after a video grant");

endmodule

// ==== src/ram_array.sv ====
`timescale 1ns/1ns

module ram_array import common_pkg::*; (
    input  logic     sys_clock_i,
    input  logic     mem_en_i,
    input  mem_req_t mem_req_i,

    output data_t    rdata_o
);
    localparam int DEPTH = 2 ** PHYS_ADDR_WIDTH;  // 128K bytes

    data_t mem [DEPTH];

    always_ff @(posedge sys_clock_i) begin
        if (mem_en_i) begin
            if (mem_req_i.write && !mem_req_i.protect) begin
                mem[mem_req_i.addr] <= mem_req_i.wdata;
            end
            rdata_o <= mem[mem_req_i.addr];     // Old data on a write cycle
        end
    end

endmodule

// ==== src/pet_bus_top.sv ====
`timescale 1ns/1ns

module pet_bus_top import common_pkg::*; #(
    parameter int CREDITS      = 2,
    parameter int SCREEN_CHARS = 1000
) (
    input  logic     sys_clock_i,
    input  logic     reset_i,
    input  logic     cpu_be_i,
    input  logic     cpu_req_valid_i,
    input  cpu_req_t cpu_req_i,
    input  logic     video_en_i,

    output logic     cpu_credit_o,
    output logic     cpu_rsp_valid_o,
    output data_t    cpu_rsp_data_o,
    output decode_t  decode_o,
    output logic     video_valid_o,
    output data_t    video_data_o
);
    mem_req_t cpu_mem_req;
    logic     cpu_mem_req_valid;
    logic     cpu_drop;
    mem_req_t vid_req;
    logic     vid_req_valid;
    logic     vid_credit;
    logic     vid_rsp_valid;
    data_t    vid_rsp_data;
    mem_req_t mem_req;
    logic     mem_en;
    data_t    mem_rdata;

    address_decoding i_address_decoding (
        .sys_clock_i     (sys_clock_i),
        .reset_i         (reset_i),
        .cpu_be_i        (cpu_be_i),
        .cpu_req_valid_i (cpu_req_valid_i),
        .cpu_req_i       (cpu_req_i),
        .decode_o        (decode_o),
        .mem_req_o       (cpu_mem_req),
        .mem_req_valid_o (cpu_mem_req_valid),
        .mem_req_drop_o  (cpu_drop)
    );

    video_fetch #(
        .CREDITS      (CREDITS),
        .SCREEN_CHARS (SCREEN_CHARS)
    ) i_video_fetch (
        .sys_clock_i   (sys_clock_i),
        .reset_i       (reset_i),
        .video_en_i    (video_en_i),
        .credit_i      (vid_credit),
        .rsp_valid_i   (vid_rsp_valid),
        .rsp_data_i    (vid_rsp_data),
        .req_o         (vid_req),
        .req_valid_o   (vid_req_valid),
        .video_valid_o (video_valid_o),
        .video_data_o  (video_data_o)
    );

    bus_arbiter #(
        .CREDITS (CREDITS)
    ) i_bus_arbiter (
        .sys_clock_i     (sys_clock_i),
        .reset_i         (reset_i),
        .cpu_req_i       (cpu_mem_req),
        .cpu_req_valid_i (cpu_mem_req_valid),
        .cpu_drop_i      (cpu_drop),
        .cpu_credit_o    (cpu_credit_o),
        .cpu_rsp_valid_o (cpu_rsp_valid_o),
        .cpu_rsp_data_o  (cpu_rsp_data_o),
        .vid_req_i       (vid_req),
        .vid_req_valid_i (vid_req_valid),
        .vid_credit_o    (vid_credit),
        .vid_rsp_valid_o (vid_rsp_valid),
        .vid_rsp_data_o  (vid_rsp_data),
        .mem_req_o       (mem_req),
        .mem_en_o        (mem_en),
        .mem_rdata_i     (mem_rdata)
    );

    ram_array i_ram_array (
        .sys_clock_i (sys_clock_i),
        .mem_en_i    (mem_en),
        .mem_req_i   (mem_req),
        .rdata_o     (mem_rdata)
    );

endmodule

// ==== dv/pet_bus_tb.sv ====
`timescale 1ns/1ns

module pet_bus_tb
    import common_pkg::*;
();
    localparam int       CREDITS      = 2;
    localparam int       SCREEN_CHARS = 1000;
    localparam int       CYCLE_LIMIT  = 20000;    // Far above the longest test sequence
    localparam mem_ctl_t CTL_ON       = mem_ctl_t'(1 << MEM_CTL_ENABLE);
    localparam mem_ctl_t CTL_SEL_LO   = mem_ctl_t'(1 << MEM_CTL_SELECT_LO);
    localparam mem_ctl_t CTL_WP_HI    = mem_ctl_t'(1 << MEM_CTL_WRITE_PROTECT_HI);
    localparam mem_ctl_t CTL_PEEKS    = mem_ctl_t'((1 << MEM_CTL_IO_PEEK)
                                                   | (1 << MEM_CTL_SCREEN_PEEK));

    logic     sys_clock = 1'b0;
    logic     reset = 1'b1;
    logic     cpu_be = 1'b1;
    logic     cpu_req_valid = 1'b0;
    cpu_req_t cpu_req = '0;
    logic     video_en = 1'b0;
    logic     cpu_credit;
    logic     cpu_rsp_valid;
    data_t    cpu_rsp_data;
    decode_t  decode;
    logic     video_valid;
    data_t    video_data;

    data_t      mem_model [phys_addr_t];          // Expected array contents
    mem_ctl_t   ctl_model = '0;
    decode_t    exp_decode = '0;
    data_t      screen_exp [SCREEN_CHARS];
    data_t      rsp_exp [16384];                  // Expected CPU read data in order
    logic       rsp_chk [16384];
    phys_addr_t rsp_pa [16384];
    int         rsp_wr = 0;
    int         rsp_rd = 0;
    int         credits = CREDITS;
    int         vid_idx = 0;
    int         vid_count = 0;
    int         cycles = 0;
    int         errors = 0;
    int         errors_at_start = 0;
    int         dec_checks = 0;
    int         rsp_checks = 0;
    cpu_addr_t  ram_written [$];

    pet_bus_top #(
        .CREDITS      (CREDITS),
        .SCREEN_CHARS (SCREEN_CHARS)
    ) i_pet_bus_top (
        .sys_clock_i     (sys_clock),
        .reset_i         (reset),
        .cpu_be_i        (cpu_be),
        .cpu_req_valid_i (cpu_req_valid),
        .cpu_req_i       (cpu_req),
        .video_en_i      (video_en),
        .cpu_credit_o    (cpu_credit),
        .cpu_rsp_valid_o (cpu_rsp_valid),
        .cpu_rsp_data_o  (cpu_rsp_data),
        .decode_o        (decode),
        .video_valid_o   (video_valid),
        .video_data_o    (video_data)
    );

    initial begin
        forever #5 sys_clock = ~sys_clock;
    end

    function automatic logic bank_hit(input cpu_addr_t a, input mem_ctl_t ctl);
        logic lo_win;
        logic hi_win;
        lo_win = a >= 16'h8000 && a <= 16'hBFFF && !(ctl[MEM_CTL_SCREEN_PEEK] && a <= 16'h8FFF);
        hi_win = a >= 16'hC000 && !(ctl[MEM_CTL_IO_PEEK] && a >= 16'hE800 && a <= 16'hEFFF);
        return ctl[MEM_CTL_ENABLE] && (lo_win || hi_win);
    endfunction

    function automatic phys_addr_t map_phys(input cpu_addr_t a, input mem_ctl_t ctl);
        logic sel;
        sel = (a >= 16'hC000) ? ctl[MEM_CTL_SELECT_HI] : ctl[MEM_CTL_SELECT_LO];
        if (bank_hit(a, ctl)) return {1'b1, sel, a[14:0]};
        return {1'b0, a};
    endfunction

    function automatic decode_t expect_decode(input cpu_addr_t a, input mem_ctl_t ctl,
                                              input logic be);
        decode_t d;
        logic    wp;
        d  = '0;
        wp = (a >= 16'hC000) ? ctl[MEM_CTL_WRITE_PROTECT_HI] : ctl[MEM_CTL_WRITE_PROTECT_LO];
        if (!be) return d;                              // Bus released, nothing selected
        d.ram_en = 1'b1;
        if (bank_hit(a, ctl)) begin
            d.is_rom = wp;
        end else if (a >= 16'h8F00 && a <= 16'h8FFF) begin
            d = '0;
            d.sid_en = 1'b1;
        end else if (a >= 16'h8000 && a <= 16'h8FFF) begin
            d.is_vram = 1'b1;
        end else if (a >= 16'hE800 && a <= 16'hE8FF) begin
            d = '0;
            d.magic_en = a <= 16'hE80F;
            d.pia1_en  = a >= 16'hE810 && a <= 16'hE81F;
            d.pia2_en  = a >= 16'hE820 && a <= 16'hE83F;
            d.via_en   = a >= 16'hE840 && a <= 16'hE87F;
            d.crtc_en  = a >= 16'hE880;
            d.io_en    = d.pia1_en || d.pia2_en || d.via_en;   // CRTC sits outside io_en
        end else if (a >= 16'h8000) begin
            d.is_rom = 1'b1;
        end
        return d;
    endfunction

    task automatic cpu_access(input cpu_addr_t a, input logic wr, input data_t wd,
                              input logic be);
        phys_addr_t pa;
        decode_t    dec;
        pa  = map_phys(a, ctl_model);
        dec = expect_decode(a, ctl_model, be);
        while (credits == 0) begin
            @(posedge sys_clock);
            #1;
        end
        cpu_req       = '{addr: a, wdata: wd, write: wr};
        cpu_be        = be;
        cpu_req_valid = 1'b1;
        exp_decode    = dec;
        credits--;
        if (be && wr && !dec.is_rom) mem_model[pa] = wd;
        if (be && wr && a == MEM_CTL_ADDR) ctl_model = wd;   // Register loads even when protected
        if (be && !wr) begin
            rsp_pa[rsp_wr]  = pa;
            rsp_chk[rsp_wr] = mem_model.exists(pa);
            if (rsp_chk[rsp_wr]) begin
                rsp_exp[rsp_wr] = mem_model[pa];
            end else begin
                rsp_exp[rsp_wr] = '0;                   // Unknown ROM byte, learned on return
            end
            rsp_wr++;
        end
        @(posedge sys_clock);
        #1;
        cpu_req_valid = 1'b0;
        cpu_be        = 1'b1;
    endtask

    task automatic write_byte(input cpu_addr_t a, input data_t d);
        cpu_access(a, 1'b1, d, 1'b1);
    endtask

    task automatic read_byte(input cpu_addr_t a);
        cpu_access(a, 1'b0, 8'h00, 1'b1);
    endtask

    task automatic set_mem_ctl(input mem_ctl_t v);
        write_byte(MEM_CTL_ADDR, v);
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while ((credits != CREDITS || rsp_rd != rsp_wr) && waited < 100) begin
            @(posedge sys_clock);
            #1;
            waited++;
        end
        if (waited >= 100) begin
            $display("Requests did not drain: %0d credits held, %0d reads unanswered",
                     CREDITS - credits, rsp_wr - rsp_rd);
            errors++;
        end
    endtask

    task automatic report_test(input string name);
        drain();
        if (errors == errors_at_start) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, errors - errors_at_start);
        end
        errors_at_start = errors;
    endtask

    always @(negedge sys_clock) begin
        if (!reset && cpu_credit === 1'b1) credits++;   // Credit usable from the next edge on
    end

    always @(posedge sys_clock) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Run stopped after %0d cycles without finishing", cycles);
            $display("Result: FAILED");
            $finish;
        end
    end

    always @(posedge sys_clock) begin
        if (!reset && cpu_req_valid) dec_checks <= dec_checks + 1;
        if (!reset && cpu_rsp_valid && rsp_rd < rsp_wr) begin
            if (!rsp_chk[rsp_rd] && !mem_model.exists(rsp_pa[rsp_rd])) begin
                mem_model[rsp_pa[rsp_rd]] = cpu_rsp_data;
            end
            if (rsp_chk[rsp_rd]) rsp_checks <= rsp_checks + 1;
            rsp_rd <= rsp_rd + 1;
        end
        if (!reset && video_valid) begin
            vid_idx   <= (vid_idx == SCREEN_CHARS - 1) ? 0 : vid_idx + 1;
            vid_count <= vid_count + 1;
        end
    end

    assert property (@(posedge sys_clock) disable iff (reset)
        cpu_req_valid |-> decode === exp_decode)
        else begin
            $display("[FAIL] %0t decode %h for address %h, expected %h",
                     $time, $sampled(decode), $sampled(cpu_req.addr), exp_decode);
            errors++;
        end

    assert property (@(posedge sys_clock) disable iff (reset)
        cpu_rsp_valid |-> rsp_rd < rsp_wr
                          && (!rsp_chk[rsp_rd] || cpu_rsp_data === rsp_exp[rsp_rd]))
        else begin
            $display("[FAIL] %0t read data %h, expected %h (read %0d of %0d issued)",
                     $time, $sampled(cpu_rsp_data), rsp_exp[$sampled(rsp_rd)],
                     $sampled(rsp_rd), rsp_wr);
            errors++;
        end

    assert property (@(posedge sys_clock) disable iff (reset)
        video_valid |-> video_data === screen_exp[vid_idx])
        else begin
            $display("[FAIL] %0t screen byte %0d is %h, expected %h",
                     $time, $sampled(vid_idx), $sampled(video_data),
                     screen_exp[$sampled(vid_idx)]);
            errors++;
        end

    assert property (@(posedge sys_clock) disable iff (reset) credits >= 0 && credits <= CREDITS)
        else begin
            $display("CPU credit count left its range: %0d", credits);
            errors++;
        end

    initial begin
        cpu_addr_t a;
        data_t     v;
        int        waited;
        cpu_addr_t map_probe [11] = '{16'h1234, 16'h8100, 16'h8F40, 16'hE805, 16'hE815,
                                      16'hE830, 16'hE860, 16'hE8A0, 16'hC000, 16'hB000, 16'hE900};
        cpu_addr_t peek_probe [5] = '{16'h8100, 16'h9100, 16'hE000, 16'hF000, 16'hE810};
        void'($urandom(15955));
        repeat (16) @(posedge sys_clock);
        #1;
        reset = 1'b0;

        foreach (map_probe[i]) read_byte(map_probe[i]);
        cpu_access(16'h1234, 1'b0, 8'h00, 1'b0);        // Dropped, credit only
        cpu_access(MEM_CTL_ADDR, 1'b1, CTL_ON, 1'b0);   // Must not reach the register
        read_byte(16'h9000);
        report_test("Test 1 base map decode and bus release");

        repeat (64) begin
            a = cpu_addr_t'($urandom_range(16'h7FFF));
            write_byte(a, data_t'($urandom));
            ram_written.push_back(a);
        end
        foreach (ram_written[i]) read_byte(ram_written[i]);
        repeat (4) begin
            a = cpu_addr_t'($urandom_range(16'hE7FF, 16'hC000));
            read_byte(a);
            drain();
            v = mem_model[map_phys(a, ctl_model)];
            write_byte(a, $isunknown(v) ? 8'hA5 : ~v);  // Differs from the byte already there
            read_byte(a);
        end
        report_test("Test 2 RAM read-back and ROM write drop");

        v = data_t'($urandom);
        set_mem_ctl(CTL_ON);
        write_byte(16'h8000, v);
        set_mem_ctl(CTL_ON | CTL_SEL_LO);
        write_byte(16'h8000, ~v);
        read_byte(16'h8000);
        set_mem_ctl(CTL_ON);
        read_byte(16'h8000);
        set_mem_ctl(8'h00);
        read_byte(16'h8000);                            // Back on VRAM
        report_test("Test 3 lower bank select");

        set_mem_ctl(CTL_ON);
        write_byte(16'hC123, v);
        write_byte(16'h9ABC, ~v);
        set_mem_ctl(CTL_ON | CTL_WP_HI);
        write_byte(16'hC123, ~v);
        write_byte(16'h9ABC, v);
        read_byte(16'hC123);
        read_byte(16'h9ABC);
        set_mem_ctl(8'h00);
        report_test("Test 4 upper bank write protect");

        set_mem_ctl(CTL_ON | CTL_PEEKS);
        foreach (peek_probe[i]) write_byte(peek_probe[i], v + data_t'(i));
        foreach (peek_probe[i]) read_byte(peek_probe[i]);
        set_mem_ctl(CTL_ON);
        read_byte(16'h8100);
        read_byte(16'hE810);
        set_mem_ctl(8'h00);
        report_test("Test 5 screen and IO peek-through");

        for (int i = 0; i < SCREEN_CHARS; i++) begin
            screen_exp[i] = data_t'($urandom);
            write_byte(16'h8000 + cpu_addr_t'(i), screen_exp[i]);
        end
        drain();
        video_en = 1'b1;
        repeat (300) begin
            if ($urandom_range(1)) begin
                a = cpu_addr_t'($urandom_range(16'h7FFF));
                write_byte(a, data_t'($urandom));
                ram_written.push_back(a);
            end else begin
                read_byte(ram_written[$urandom_range(ram_written.size() - 1)]);
            end
        end
        waited = 0;
        while (vid_count < SCREEN_CHARS + 100 && waited < 5000) begin   // Past the wrap
            @(posedge sys_clock);
            #1;
            waited++;
        end
        if (vid_count < SCREEN_CHARS + 100) begin
            $display("Screen stream stalled after %0d bytes", vid_count);
            errors++;
        end
        video_en = 1'b0;
        report_test("Test 6 screen streaming under CPU traffic");

        $display("Summary: 6 tests, %0d decode checks, %0d read checks, %0d screen bytes, %0d errors",
                 dec_checks, rsp_checks, vid_count, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== project.f ====
src/common_pkg.sv
src/memory_control.sv
src/address_decoding.sv
src/video_fetch.sv
src/bus_arbiter.sv
src/ram_array.sv
src/pet_bus_top.sv
dv/pet_bus_tb.sv
